// ==== hw/taylor_pkg.sv ====
`default_nettype none

package taylor_pkg;

    // ------------------------------
    // Number format
    // ------------------------------

    // Signed Q2.16
    typedef logic signed [17:0] fix_t;

    localparam int FRAC_BITS = 16;

    localparam fix_t FIX_ONE = 18'sh10000;
    localparam fix_t FIX_MAX = 18'sh1ffff;
    localparam fix_t FIX_MIN = 18'sh20000;

    // Function select where code 3 is invalid
    typedef enum logic [1:0] {
        FUNC_SIN = 2'd0,
        FUNC_COS = 2'd1,
        FUNC_EXP = 2'd2
    } func_e;

    // ------------------------------
    // Register map
    // ------------------------------
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_X      = 4'h4;
    localparam logic [3:0] REG_STATUS = 4'h8;
    localparam logic [3:0] REG_RESULT = 4'hc;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        done;
        logic        busy;
    } status_t;

    // Register block to sequencer
    typedef struct packed {
        func_e func;
        fix_t  x;
    } calc_req_t;

    typedef struct packed {
        logic done;
        fix_t result;
    } calc_rsp_t;

endpackage

`default_nettype wire

// ==== hw/dsp_pkg.sv ====
`default_nettype none

package dsp_pkg;

    localparam int AB_W = 18;
    localparam int M_W  = 36;
    localparam int P_W  = 48;

    // X mux in front of the post adder
    typedef enum logic [1:0] {
        X_ZERO = 2'd0,
        X_MULT = 2'd1
    } x_sel_e;

    // Z mux on the accumulator feedback path
    typedef enum logic [1:0] {
        Z_ZERO = 2'd0,
        Z_POUT = 2'd1
    } z_sel_e;

    typedef struct packed {
        x_sel_e x_sel;
        z_sel_e z_sel;
        logic   sub;
    } dsp_opmode_t;

    typedef struct packed {
        dsp_opmode_t            opmode;
        logic signed [AB_W-1:0] a;
        logic signed [AB_W-1:0] b;
    } dsp_in_t;

    typedef struct packed {
        logic signed [M_W-1:0] m;
        logic signed [P_W-1:0] p;
    } dsp_out_t;

endpackage

`default_nettype wire

// ==== hw/dsp_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module dsp_slice (
    input  wire               reset,
    input  wire               clk,
    input  dsp_pkg::dsp_in_t  dsp_in,
    output dsp_pkg::dsp_out_t dsp_out
);

    dsp_pkg::dsp_opmode_t             op_r;
    logic signed [dsp_pkg::AB_W-1:0]  a_r;
    logic signed [dsp_pkg::AB_W-1:0]  b_r;
    logic signed [dsp_pkg::M_W-1:0]   prod;
    logic signed [dsp_pkg::P_W-1:0]   x_mux;
    logic signed [dsp_pkg::P_W-1:0]   z_mux;
    logic signed [dsp_pkg::M_W-1:0]   m_r;
    logic signed [dsp_pkg::P_W-1:0]   p_r;

    // Input register stage
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_r <= '{x_sel: dsp_pkg::X_ZERO, z_sel: dsp_pkg::Z_POUT, sub: 1'b0};
        end else begin
            op_r <= dsp_in.opmode;
        end
    end

    always_ff @(posedge reset) begin
        a_r <= dsp_in.a;
        b_r <= dsp_in.b;
    end

    assign prod = a_r * b_r;

    always_comb begin
        case (op_r.x_sel)
            dsp_pkg::X_MULT: x_mux = {{(dsp_pkg::P_W - dsp_pkg::M_W){prod[dsp_pkg::M_W-1]}}, prod};
            default:         x_mux = '0;
        endcase
        case (op_r.z_sel)
            dsp_pkg::Z_POUT: z_mux = p_r;
            default:         z_mux = '0;
        endcase
    end

    // Product and accumulator stage
    always_ff @(posedge reset) begin
        m_r <= prod;
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p_r <= '0;
        end else if (op_r.sub) begin
            p_r <= z_mux - x_mux;
        end else begin
            p_r <= z_mux + x_mux;
        end
    end

    assign dsp_out.m = m_r;
    assign dsp_out.p = p_r;

    // Opmode must be driven to known values once out of reset
    assert property (@(posedge reset) disable iff (clk)
        !$isunknown(dsp_in.opmode))
        else $error("dsp_slice opmode unknown");

endmodule

`default_nettype wire

// ==== hw/taylor_coef_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module taylor_coef_rom #(
    parameter int N_TERMS = 10
) (
    input  taylor_pkg::func_e func,
    input  wire [3:0]         term_idx,
    output taylor_pkg::fix_t  deriv_coef,
    output taylor_pkg::fix_t  recip
);

    // Derivative at zero repeats every four terms
    always_comb begin
        case (func)
            taylor_pkg::FUNC_SIN: begin
                case (term_idx[1:0])
                    2'd1:    deriv_coef = taylor_pkg::FIX_ONE;
                    2'd3:    deriv_coef = -taylor_pkg::FIX_ONE;
                    default: deriv_coef = '0;
                endcase
            end
            taylor_pkg::FUNC_COS: begin
                case (term_idx[1:0])
                    2'd0:    deriv_coef = taylor_pkg::FIX_ONE;
                    2'd2:    deriv_coef = -taylor_pkg::FIX_ONE;
                    default: deriv_coef = '0;
                endcase
            end
            taylor_pkg::FUNC_EXP: deriv_coef = taylor_pkg::FIX_ONE;
            default:              deriv_coef = '0;
        endcase
    end

    // 1/n in Q2.16
    always_comb begin
        case (term_idx)
            4'd1:    recip = 18'sh10000;
            4'd2:    recip = 18'sh08000;
            4'd3:    recip = 18'sh05555;
            4'd4:    recip = 18'sh04000;
            4'd5:    recip = 18'sh03333;
            4'd6:    recip = 18'sh02aab;
            4'd7:    recip = 18'sh02492;
            4'd8:    recip = 18'sh02000;
            4'd9:    recip = 18'sh01c72;
            4'd10:   recip = 18'sh0199a;
            4'd11:   recip = 18'sh01746;
            4'd12:   recip = 18'sh01555;
            4'd13:   recip = 18'sh013b1;
            4'd14:   recip = 18'sh01249;
            4'd15:   recip = 18'sh01111;
            default: recip = taylor_pkg::FIX_ONE;
        endcase
    end

    always_comb begin
        if (!$isunknown(term_idx)) begin
            assert (term_idx <= N_TERMS)
                else $error("taylor_coef_rom index %0d above %0d", term_idx, N_TERMS);
        end
    end

endmodule

`default_nettype wire

// ==== hw/taylor_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module taylor_calc #(
    parameter int N_TERMS = 10
) (
    input  wire                   reset,
    input  wire                   clk,
    input  wire                   start,
    input  taylor_pkg::calc_req_t req,
    input  taylor_pkg::fix_t      deriv_coef,
    input  taylor_pkg::fix_t      recip,
    input  dsp_pkg::dsp_out_t     dsp_out,
    output taylor_pkg::calc_rsp_t rsp,
    output logic [3:0]            term_idx,
    output taylor_pkg::func_e     func,
    output dsp_pkg::dsp_in_t      dsp_in
);

    typedef enum logic [3:0] {
        ST_IDLE, ST_LOAD, ST_INIT, ST_POWER_A, ST_WEIGHT, ST_POWER_B, ST_POWER_W,
        ST_DRAIN, ST_DONE
    } state_e;

    state_e           state;
    logic [3:0]       k;
    logic             drain_cnt;
    logic             last_term;
    taylor_pkg::fix_t x_q;
    taylor_pkg::fix_t m_fix;
    taylor_pkg::fix_t val [0:15];
    logic             store_trig;
    logic [3:0]       store_idx;
    logic [1:0]       store_trig_dly;
    logic [3:0]       store_idx_dly [0:1];
    logic             done_q;
    taylor_pkg::fix_t result_q;

    // Round a Q.32 value back to Q2.16 with saturation
    function automatic taylor_pkg::fix_t sat_round(input logic signed [47:0] v);
        logic signed [47:0] r;
        r = (v + (48'sd1 <<< (taylor_pkg::FRAC_BITS - 1))) >>> taylor_pkg::FRAC_BITS;
        if (r > 48'(taylor_pkg::FIX_MAX)) begin
            return taylor_pkg::FIX_MAX;
        end else if (r < 48'(taylor_pkg::FIX_MIN)) begin
            return taylor_pkg::FIX_MIN;
        end
        return r[17:0];
    endfunction

    assign last_term = (k == 4'(N_TERMS));
    assign m_fix     = sat_round({{12{dsp_out.m[35]}}, dsp_out.m});

    // ------------------------------
    // Sequencer
    // ------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state     <= ST_IDLE;
            k         <= '0;
            drain_cnt <= 1'b0;
        end else begin
            case (state)
                ST_IDLE:    if (start) state <= ST_LOAD;
                ST_LOAD:    state <= ST_INIT;
                ST_INIT: begin
                    k     <= 4'd1;
                    state <= ST_POWER_A;
                end
                ST_POWER_A: state <= ST_WEIGHT;
                ST_WEIGHT:  state <= ST_POWER_B;
                ST_POWER_B: state <= ST_POWER_W;
                ST_POWER_W: begin
                    if (last_term) begin
                        state     <= ST_DRAIN;
                        drain_cnt <= 1'b0;
                    end else begin
                        k     <= k + 4'd1;
                        state <= ST_POWER_A;
                    end
                end
                ST_DRAIN: begin
                    drain_cnt <= 1'b1;
                    if (drain_cnt) state <= ST_DONE;
                end
                ST_DONE: begin
                    k     <= '0;
                    state <= ST_IDLE;
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            func <= taylor_pkg::FUNC_SIN;
        end else if (state == ST_LOAD) begin
            func <= req.func;
        end
    end

    always_ff @(posedge reset) begin
        if (state == ST_LOAD) x_q <= req.x;
    end

    // Weighting looks back one term
    assign term_idx = (state == ST_WEIGHT) ? k - 4'd1 : k;

    // ------------------------------
    // DSP operation control
    // ------------------------------
    always_comb begin
        dsp_in.opmode = '{x_sel: dsp_pkg::X_ZERO, z_sel: dsp_pkg::Z_POUT, sub: 1'b0};
        dsp_in.a      = '0;
        dsp_in.b      = '0;
        store_trig    = 1'b0;
        store_idx     = k;
        case (state)
            // Clear the accumulator
            ST_INIT: dsp_in.opmode.z_sel = dsp_pkg::Z_ZERO;
            // v(k-1) times 1/k while the previous term still sits in m
            ST_POWER_A: begin
                if (!last_term) begin
                    dsp_in.a = (k == 4'd1) ? val[0] : m_fix;
                    dsp_in.b = recip;
                end
            end
            ST_WEIGHT: begin
                dsp_in.opmode.x_sel = dsp_pkg::X_MULT;
                dsp_in.a            = val[k-1];
                dsp_in.b            = deriv_coef;
            end
            ST_POWER_B: begin
                if (!last_term) begin
                    dsp_in.a   = m_fix;
                    dsp_in.b   = x_q;
                    store_trig = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // Store index follows the product through the slice
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            store_trig_dly   <= '0;
            store_idx_dly[0] <= '0;
            store_idx_dly[1] <= '0;
        end else begin
            store_trig_dly   <= {store_trig_dly[0], store_trig};
            store_idx_dly[0] <= store_idx;
            store_idx_dly[1] <= store_idx_dly[0];
        end
    end

    always_ff @(posedge reset) begin
        if (state == ST_INIT) begin
            val[0] <= taylor_pkg::FIX_ONE;
        end else if (store_trig_dly[1]) begin
            val[store_idx_dly[1]] <= m_fix;
        end
    end

    // Result capture
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state == ST_DONE);
        end
    end

    always_ff @(posedge reset) begin
        if (state == ST_DONE) result_q <= sat_round(dsp_out.p);
    end

    assign rsp.done   = done_q;
    assign rsp.result = result_q;

    assert property (@(posedge reset) disable iff (clk) term_idx <= N_TERMS)
        else $error("taylor_calc term index out of range");

    // Register block holds off start until the previous result is back
    assert property (@(posedge reset) disable iff (clk) start |-> state == ST_IDLE)
        else $error("taylor_calc start while busy");

endmodule

`default_nettype wire

// ==== hw/apb_func_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_func_regs (
    input  wire                   reset,
    input  wire                   clk,
    input  wire [3:0]             paddr,
    input  wire                   psel,
    input  wire                   penable,
    input  wire                   pwrite,
    input  wire [31:0]            pwdata,
    input  taylor_pkg::calc_rsp_t rsp,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output taylor_pkg::calc_req_t req,
    output logic                  start,
    output logic                  irq
);

    logic                access;
    logic                wr_en;
    logic                rd_en;
    logic                locked;
    logic                func_ok;
    logic                wr_x;
    logic                wr_ctrl;
    logic                rd_result;
    logic                busy;
    logic                done;
    taylor_pkg::fix_t    x_q;
    taylor_pkg::func_e   func_q;
    taylor_pkg::fix_t    result_q;
    taylor_pkg::status_t status;

    // ------------------------------
    // Access decode
    // ------------------------------
    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign rd_en   = access && !pwrite;
    assign locked  = busy || start;
    assign func_ok = (pwdata[2:1] != 2'd3);

    assign wr_x      = wr_en && (paddr == taylor_pkg::REG_X) && !locked;
    assign wr_ctrl   = wr_en && (paddr == taylor_pkg::REG_CTRL) && !locked && func_ok;
    assign rd_result = rd_en && (paddr == taylor_pkg::REG_RESULT);

    // Zero wait states
    assign pready = 1'b1;

    always_comb begin
        pslverr = 1'b0;
        if (wr_en && paddr == taylor_pkg::REG_X && locked) begin
            pslverr = 1'b1;
        end
        if (wr_en && paddr == taylor_pkg::REG_CTRL) begin
            pslverr = locked || (pwdata[0] && !func_ok);
        end
    end

    // Argument and function
    always_ff @(posedge reset) begin
        if (wr_x) x_q <= pwdata[17:0];
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            func_q <= taylor_pkg::FUNC_SIN;
            start  <= 1'b0;
        end else begin
            start <= wr_ctrl && pwdata[0];
            if (wr_ctrl) func_q <= taylor_pkg::func_e'(pwdata[2:1]);
        end
    end

    assign req.func = func_q;
    assign req.x    = x_q;

    // Busy, sticky done and result
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            result_q <= '0;
        end else begin
            if (rsp.done) begin
                busy     <= 1'b0;
                done     <= 1'b1;
                result_q <= rsp.result;
            end else begin
                if (start) busy <= 1'b1;
                if (rd_result) done <= 1'b0;
            end
        end
    end

    assign irq = done;

    always_comb begin
        status      = '0;
        status.busy = busy;
        status.done = done;
        prdata      = '0;
        if (rd_en) begin
            case (paddr)
                taylor_pkg::REG_CTRL:   prdata = {29'd0, func_q, 1'b0};
                taylor_pkg::REG_X:      prdata = {{14{x_q[17]}}, x_q};
                taylor_pkg::REG_STATUS: prdata = status;
                taylor_pkg::REG_RESULT: prdata = {{14{result_q[17]}}, result_q};
                default:                prdata = '0;
            endcase
        end
    end

    assert property (@(posedge reset) disable iff (clk) penable |-> psel)
        else $error("apb penable without psel");

endmodule

`default_nettype wire

// ==== hw/taylor_alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module taylor_alu_top #(
    parameter int N_TERMS = 10
) (
    input  wire        reset,
    input  wire        clk,
    input  wire [3:0]  paddr,
    input  wire        psel,
    input  wire        penable,
    input  wire        pwrite,
    input  wire [31:0] pwdata,
    output logic [31:0] prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       irq
);

    taylor_pkg::calc_req_t req;
    taylor_pkg::calc_rsp_t rsp;
    logic                  start;
    logic [3:0]            term_idx;
    taylor_pkg::func_e     func;
    taylor_pkg::fix_t      deriv_coef;
    taylor_pkg::fix_t      recip;
    dsp_pkg::dsp_in_t      dsp_in;
    dsp_pkg::dsp_out_t     dsp_out;

    apb_func_regs u_apb_func_regs (
        .reset   (reset),
        .clk     (clk),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .rsp     (rsp),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .start   (start),
        .irq     (irq)
    );

    taylor_calc #(.N_TERMS(N_TERMS)) u_taylor_calc (
        .reset      (reset),
        .clk        (clk),
        .start      (start),
        .req        (req),
        .deriv_coef (deriv_coef),
        .recip      (recip),
        .dsp_out    (dsp_out),
        .rsp        (rsp),
        .term_idx   (term_idx),
        .func       (func),
        .dsp_in     (dsp_in)
    );

    taylor_coef_rom #(.N_TERMS(N_TERMS)) u_taylor_coef_rom (
        .func       (func),
        .term_idx   (term_idx),
        .deriv_coef (deriv_coef),
        .recip      (recip)
    );

    dsp_slice u_dsp_slice (
        .reset   (reset),
        .clk     (clk),
        .dsp_in  (dsp_in),
        .dsp_out (dsp_out)
    );

endmodule

`default_nettype wire

// ==== include/taylor_alu_vectors.svh ====
`ifndef TAYLOR_ALU_VECTORS_SVH
`define TAYLOR_ALU_VECTORS_SVH

typedef struct packed {
    logic [1:0]  func;
    logic [17:0] x;
    logic [17:0] expected;
    logic        expect_error;
} vec_t;

localparam int NUM_VEC = 18;

// Each row holds func, x (Q2.16), expected result (Q2.16) and expect_error
// Expected values are round(f(x) * 65536) of the true function
// expect_error on a valid func adds X and CTRL writes while busy
localparam vec_t VECTORS [NUM_VEC] = '{
    '{taylor_pkg::FUNC_SIN, 18'h00000, 18'h00000, 1'b0},
    '{taylor_pkg::FUNC_SIN, 18'h08000, 18'h07abc, 1'b0},
    '{taylor_pkg::FUNC_SIN, 18'h38000, 18'h38544, 1'b0},
    '{taylor_pkg::FUNC_SIN, 18'h10000, 18'h0d76b, 1'b0},
    '{taylor_pkg::FUNC_SIN, 18'h30000, 18'h32895, 1'b0},
    '{taylor_pkg::FUNC_SIN, 18'h14000, 18'h0f2f1, 1'b0},
    '{taylor_pkg::FUNC_COS, 18'h00000, 18'h10000, 1'b0},
    '{taylor_pkg::FUNC_COS, 18'h04000, 18'h0f80b, 1'b0},
    '{taylor_pkg::FUNC_COS, 18'h08000, 18'h0e0a9, 1'b0},
    '{taylor_pkg::FUNC_COS, 18'h30000, 18'h08a51, 1'b0},
    '{taylor_pkg::FUNC_EXP, 18'h00000, 18'h10000, 1'b0},
    '{taylor_pkg::FUNC_EXP, 18'h04000, 18'h148b6, 1'b0},
    '{taylor_pkg::FUNC_EXP, 18'h08000, 18'h1a613, 1'b0},
    '{taylor_pkg::FUNC_EXP, 18'h38000, 18'h09b46, 1'b0},
    '{taylor_pkg::FUNC_EXP, 18'h30000, 18'h05e2d, 1'b0},
    // Writes during busy must not disturb these
    '{taylor_pkg::FUNC_SIN, 18'h0c000, 18'h0ae80, 1'b1},
    '{taylor_pkg::FUNC_COS, 18'h0c000, 18'h0bb50, 1'b1},
    // Invalid func code so the start is refused
    '{2'd3,                 18'h08000, 18'h00000, 1'b1}
};

`endif

// ==== tb/taylor_alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module taylor_alu_tb;

    localparam int N_TERMS   = 10;
    localparam int N_RANDOM  = 20;
    localparam int TOL_LSB   = 8;
    localparam int CALC_CYC  = 4 * N_TERMS + 6;

    `include "taylor_alu_vectors.svh"

    localparam int CYCLE_LIMIT = (NUM_VEC + N_RANDOM) * (4 * N_TERMS + 20);

    // The clock is named reset and the async reset clk
    logic        reset;
    logic        clk;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    int cycle_cnt;
    int check_cnt;
    int err_cnt;

    taylor_alu_top #(.N_TERMS(N_TERMS)) u_taylor_alu_top (
        .reset   (reset),
        .clk     (clk),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #2 reset = ~reset;

    always @(posedge reset) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT never finished", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got == exp) else begin
            err_cnt++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_close(input string name, input int got, input int exp);
        check_cnt++;
        assert ((got - exp) <= TOL_LSB && (exp - got) <= TOL_LSB) else begin
            err_cnt++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Nearest Q2.16 value clipped to the format range
    function automatic int real_to_fix(input real v);
        real scaled;
        int  fx;
        scaled = v * 65536.0;
        if (scaled >= 0.0) begin
            fx = $rtoi(scaled + 0.5);
        end else begin
            fx = $rtoi(scaled - 0.5);
        end
        if (fx > 131071) begin
            fx = 131071;
        end else if (fx < -131072) begin
            fx = -131072;
        end
        return fx;
    endfunction

    // ------------------------------
    // APB transfers
    // ------------------------------
    // Called on a falling edge and returns on one with the bus idle
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge reset);
        penable = 1'b1;
        #1;
        err = pslverr;
        check_value("pready", pready, 1);
        @(negedge reset);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge reset);
        penable = 1'b1;
        #1;
        data = prdata;
        err  = pslverr;
        check_value("pready", pready, 1);
        @(negedge reset);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // One calculation with a valid func that leaves its result in result
    task automatic run_case(input logic [1:0] func, input logic [17:0] x,
                            input logic busy_writes, output logic [31:0] result);
        logic [31:0] rdata;
        logic        err;
        logic [1:0]  other_func;
        int          start_cycle;
        int          latency;
        other_func = (func == 2'd2) ? 2'd0 : func + 2'd1;
        apb_write(taylor_pkg::REG_X, {{14{x[17]}}, x}, err);
        check_value("pslverr X write", err, 0);
        apb_write(taylor_pkg::REG_CTRL, {29'd0, func, 1'b1}, err);
        check_value("pslverr CTRL start", err, 0);
        // Sequencer takes the start pulse on the next edge
        start_cycle = cycle_cnt + 1;
        apb_read(taylor_pkg::REG_STATUS, rdata, err);
        check_value("prdata(STATUS) while busy", rdata, 32'h1);
        if (busy_writes) begin
            apb_write(taylor_pkg::REG_X, {{14{x[17]}}, x ^ 18'h01000}, err);
            check_value("pslverr X write while busy", err, 1);
            apb_write(taylor_pkg::REG_CTRL, {29'd0, other_func, 1'b1}, err);
            check_value("pslverr CTRL write while busy", err, 1);
            apb_read(taylor_pkg::REG_X, rdata, err);
            check_value("prdata(X) after refused write", rdata, {{14{x[17]}}, x});
            apb_read(taylor_pkg::REG_CTRL, rdata, err);
            check_value("prdata(CTRL) after refused write", rdata, {29'd0, func, 1'b0});
            apb_read(taylor_pkg::REG_STATUS, rdata, err);
            check_value("prdata(STATUS) after refused writes", rdata, 32'h1);
        end
        while (!irq) begin
            @(negedge reset);
        end
        latency = cycle_cnt - start_cycle;
        check_value("calc_cycles", latency, CALC_CYC);
        apb_read(taylor_pkg::REG_STATUS, rdata, err);
        check_value("prdata(STATUS) at done", rdata, 32'h2);
        apb_read(taylor_pkg::REG_RESULT, result, err);
        check_value("irq after RESULT read", irq, 0);
    endtask

    task automatic refused_start_case(input logic [17:0] x);
        logic [31:0] rdata;
        logic        err;
        apb_write(taylor_pkg::REG_X, {{14{x[17]}}, x}, err);
        check_value("pslverr X write", err, 0);
        apb_write(taylor_pkg::REG_CTRL, {29'd0, 2'd3, 1'b1}, err);
        check_value("pslverr CTRL func 3", err, 1);
        apb_read(taylor_pkg::REG_STATUS, rdata, err);
        check_value("prdata(STATUS) after func 3", rdata, 0);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [1:0]  rfunc;
        int          xi;
        real         xr;
        real         fr;
        void'($urandom(98));
        cycle_cnt = 0;
        check_cnt = 0;
        err_cnt   = 0;
        reset     = 1'b0;
        clk       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        repeat (3) @(posedge reset);
        @(negedge reset);
        clk = 1'b0;

        // Idle state after reset
        check_value("irq after reset", irq, 0);
        apb_read(taylor_pkg::REG_STATUS, rdata, err);
        check_value("prdata(STATUS) after reset", rdata, 0);
        check_value("pslverr STATUS read", err, 0);
        apb_read(taylor_pkg::REG_RESULT, rdata, err);
        check_value("prdata(RESULT) after reset", rdata, 0);

        for (int i = 0; i < NUM_VEC; i++) begin
            if (VECTORS[i].func == 2'd3) begin
                refused_start_case(VECTORS[i].x);
            end else begin
                run_case(VECTORS[i].func, VECTORS[i].x, VECTORS[i].expect_error, rdata);
                compare_close("prdata(RESULT)", $signed(rdata), $signed(VECTORS[i].expected));
                apb_read(taylor_pkg::REG_STATUS, rdata, err);
                check_value("prdata(STATUS) after RESULT read", rdata, 0);
            end
        end

        // Random arguments in +-1.0 against the real math functions
        for (int n = 0; n < N_RANDOM; n++) begin
            rfunc = 2'($urandom_range(2));
            xi    = int'($urandom_range(131072)) - 65536;
            xr    = $itor(xi) / 65536.0;
            case (rfunc)
                2'd0:    fr = $sin(xr);
                2'd1:    fr = $cos(xr);
                default: fr = $exp(xr);
            endcase
            run_case(rfunc, xi[17:0], 1'b0, rdata);
            compare_close("prdata(RESULT) random", $signed(rdata), real_to_fix(fr));
        end

        $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/taylor_pkg.sv
hw/dsp_pkg.sv
hw/dsp_slice.sv
hw/taylor_coef_rom.sv
hw/taylor_calc.sv
hw/apb_func_regs.sv
hw/taylor_alu_top.sv
tb/taylor_alu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the Taylor function unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module taylor_alu_tb \
    -f build.f \
    -o taylor_alu_sim

./obj_dir/taylor_alu_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Test FAILED, see sim.log"
    exit 1
fi

echo "Test passed"
